// File: hw/isa_pkg.sv
////////////////////////////////////////////////////////////////////////////
// integer ISA definitions for the execute and memory back end
// widths, ALU and memory operation codes, and the data memory geometry
// imported by every stage that handles words, registers or opcodes
////////////////////////////////////////////////////////////////////////////
package isa_pkg;

    // datapath word and register file address
    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;

    // data memory, word addressed
    localparam int dmem_depth    = 64;
    localparam int dmem_addr_w   = $clog2(dmem_depth);
    // byte address bits below the word index
    localparam int dmem_addr_lsb = 2;

    // opcode field widths
    localparam int alu_op_w = 4;
    localparam int mem_op_w = 2;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // eight ALU functions, codes 8..15 are unused and yield 0
    typedef enum logic [alu_op_w-1:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_sll = 4'd5,
        alu_srl = 4'd6,
        alu_sra = 4'd7
    } alu_op_t;

    // memory access kind, code 3 is unused
    typedef enum logic [mem_op_w-1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_t;

endpackage

// File: hw/pipe_pkg.sv
////////////////////////////////////////////////////////////////////////////
// payloads of the pipeline registers between ID, EX, MEM and WB
// valid bits travel beside these structs on separate wires
////////////////////////////////////////////////////////////////////////////
package pipe_pkg;

    import isa_pkg::*;

    // issued instruction, contents of the ID/EX register
    typedef struct packed {
        alu_op_t   alu_op;
        // operand 0, may be replaced by the MEM result
        word_t     alu_in_0;
        // operand 1, register value or immediate
        word_t     alu_in_1;
        // source register of alu_in_0
        reg_addr_t ra_addr;
        // source register of the store data
        reg_addr_t rb_addr;
        mem_op_t   mem_op;
        word_t     mem_wr_data;
        reg_addr_t dst_addr;
        // high when the result goes to the register file
        logic      gpr_we;
    } id_ex_t;

    // EX/MEM register
    typedef struct packed {
        mem_op_t   mem_op;
        // store data after forwarding
        word_t     mem_wr_data;
        reg_addr_t dst_addr;
        logic      gpr_we;
        // ALU result, also the memory byte address
        word_t     ex_out;
    } ex_mem_t;

    // MEM/WB register
    typedef struct packed {
        reg_addr_t dst_addr;
        logic      gpr_we;
        // load data or ALU result
        word_t     wb_data;
    } mem_wb_t;

endpackage

// File: hw/alu.sv
////////////////////////////////////////////////////////////////////////////
// combinational integer ALU of the EX stage
// eight functions selected by alu_op_t, unused codes give zero
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module alu
    import isa_pkg::*;
(
    input  word_t   arg_0,
    input  word_t   arg_1,
    input  alu_op_t op,
    output word_t   val
);

    // shift amount, low five bits of the second operand
    logic [4:0] shamt;

    assign shamt = arg_1[4:0];

    always_comb begin
        case (op)
            alu_add: begin
                val = arg_0 + arg_1;
            end
            alu_sub: begin
                val = arg_0 - arg_1;
            end
            alu_and: begin
                val = arg_0 & arg_1;
            end
            alu_or: begin
                val = arg_0 | arg_1;
            end
            alu_xor: begin
                val = arg_0 ^ arg_1;
            end
            alu_sll: begin
                val = arg_0 << shamt;
            end
            alu_srl: begin
                val = arg_0 >> shamt;
            end
            alu_sra: begin
                // arithmetic, sign bit fills from the left
                val = word_t'($signed(arg_0) >>> shamt);
            end
            default: begin
                val = '0;
            end
        endcase
    end

endmodule

// File: hw/pipe_reg.sv
////////////////////////////////////////////////////////////////////////////
// generic stage register, a valid bit plus a payload of any packed type
// used for both the EX/MEM and the MEM/WB register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    // freeze, keeps valid and payload as they are
    input  logic     stall,
    input  logic     in_en,
    input  payload_t in_data,
    output logic     out_en,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_en   <= 1'b0;
            out_data <= '0;
        end else if (!stall) begin
            // bubble moves through when in_en is low
            out_en   <= in_en;
            out_data <= in_data;
        end
    end

endmodule

// File: hw/fwd_unit.sv
////////////////////////////////////////////////////////////////////////////
// bypass decision for the instruction entering EX
// compares both source registers with the MEM stage destination
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module fwd_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    // sources of the issued instruction
    input  reg_addr_t ra_addr,
    input  reg_addr_t rb_addr,
    // instruction now in MEM
    input  logic      mem_en,
    input  ex_mem_t   mem,
    output logic      ra_fwd_en,
    output logic      rb_fwd_en
);

    // MEM instruction will write a real register
    logic mem_wr;

    // r0 is hard zero, never a forward target
    assign mem_wr = mem_en && mem.gpr_we && (mem.dst_addr != '0);

    // one comparator per source
    // ra feeds alu_in_0
    assign ra_fwd_en = mem_wr && (mem.dst_addr == ra_addr);
    // rb feeds the store data
    assign rb_fwd_en = mem_wr && (mem.dst_addr == rb_addr);

endmodule

// File: hw/ex_stage.sv
////////////////////////////////////////////////////////////////////////////
// execute stage, operand forwarding, ALU and the EX/MEM register
// flush kills the instruction in EX, stall holds the register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module ex_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,
    input  logic    flush,
    // ID/EX contents
    input  logic    id_en,
    input  id_ex_t  id,
    // bypass from MEM
    input  logic    ra_fwd_en,
    input  logic    rb_fwd_en,
    input  word_t   mem_fwd_data,
    // EX/MEM register
    output logic    ex_en,
    output ex_mem_t ex
);

    word_t   alu_in_0;
    word_t   st_data;
    word_t   alu_out;
    logic    ex_next_en;
    ex_mem_t ex_next;

    // operand 0 takes the MEM result on a hazard
    assign alu_in_0 = ra_fwd_en ? mem_fwd_data : id.alu_in_0;
    // store data forwarded the same way
    // alu_in_1 stays, it may be an immediate
    assign st_data  = rb_fwd_en ? mem_fwd_data : id.mem_wr_data;

    alu u_alu (
        .arg_0 (alu_in_0),
        .arg_1 (id.alu_in_1),
        .op    (id.alu_op),
        .val   (alu_out)
    );

    // EX/MEM payload, result is always the ALU value
    always_comb begin
        ex_next.mem_op      = id.mem_op;
        ex_next.mem_wr_data = st_data;
        ex_next.dst_addr    = id.dst_addr;
        ex_next.gpr_we      = id.gpr_we;
        ex_next.ex_out      = alu_out;
    end

    // flushed instruction enters MEM as a bubble
    assign ex_next_en = id_en && !flush;

    // stall wins over flush, register just holds
    pipe_reg #(
        .payload_t (ex_mem_t)
    ) u_ex_mem_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .in_en    (ex_next_en),
        .in_data  (ex_next),
        .out_en   (ex_en),
        .out_data (ex)
    );

endmodule

// File: hw/mem_stage.sv
////////////////////////////////////////////////////////////////////////////
// memory stage, word addressed data memory and the MEM/WB register
// loads read asynchronously, stores write at the MEM/WB load edge
// the MEM result also feeds the bypass into EX
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mem_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,
    // EX/MEM register
    input  logic    ex_en,
    input  ex_mem_t ex,
    // MEM result to the forwarding muxes
    output word_t   mem_fwd_data,
    // MEM/WB register
    output logic    wb_en,
    output mem_wb_t wb
);

    word_t                  dmem [dmem_depth];
    logic [dmem_addr_w-1:0] dmem_addr;
    logic                   dmem_we;
    word_t                  rd_data;
    mem_wb_t                wb_next;

    // word index from the byte address
    assign dmem_addr = ex.ex_out[dmem_addr_lsb +: dmem_addr_w];

    // valid store only, nothing written while stalled
    assign dmem_we = ex_en && (ex.mem_op == mem_store) && !stall;

    // contents cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_depth; i++) begin
                dmem[i] <= '0;
            end
        end else if (dmem_we) begin
            dmem[dmem_addr] <= ex.mem_wr_data;
        end
    end

    // async read, same cycle as the address
    assign rd_data = dmem[dmem_addr];

    // load data for loads, ALU result for everything else
    assign mem_fwd_data = (ex.mem_op == mem_load) ? rd_data : ex.ex_out;

    always_comb begin
        wb_next.dst_addr = ex.dst_addr;
        wb_next.gpr_we   = ex.gpr_we;
        wb_next.wb_data  = mem_fwd_data;
    end

    pipe_reg #(
        .payload_t (mem_wb_t)
    ) u_mem_wb_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .in_en    (ex_en),
        .in_data  (wb_next),
        .out_en   (wb_en),
        .out_data (wb)
    );

endmodule

// File: hw/exec_core.sv
////////////////////////////////////////////////////////////////////////////
// top of the execute and memory back end
// takes the issued ID/EX payload, returns the MEM/WB payload two
// cycles later, one more cycle per stalled cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module exec_core
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,
    input  logic    flush,
    // issue strobe and payload
    input  logic    id_en,
    input  id_ex_t  id,
    // writeback strobe and payload
    output logic    wb_en,
    output mem_wb_t wb
);

    logic    ra_fwd_en;
    logic    rb_fwd_en;
    word_t   mem_fwd_data;
    // EX/MEM register, seen by MEM and the bypass logic
    logic    ex_en;
    ex_mem_t ex;

    fwd_unit u_fwd_unit (
        .ra_addr   (id.ra_addr),
        .rb_addr   (id.rb_addr),
        .mem_en    (ex_en),
        .mem       (ex),
        .ra_fwd_en (ra_fwd_en),
        .rb_fwd_en (rb_fwd_en)
    );

    ex_stage u_ex_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .flush        (flush),
        .id_en        (id_en),
        .id           (id),
        .ra_fwd_en    (ra_fwd_en),
        .rb_fwd_en    (rb_fwd_en),
        .mem_fwd_data (mem_fwd_data),
        .ex_en        (ex_en),
        .ex           (ex)
    );

    mem_stage u_mem_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .ex_en        (ex_en),
        .ex           (ex),
        .mem_fwd_data (mem_fwd_data),
        .wb_en        (wb_en),
        .wb           (wb)
    );

endmodule

// File: verification/exec_core_checker.sv
////////////////////////////////////////////////////////////////////////////
// bound checker for exec_core, watches the top ports only
// a shadow pipeline and data memory give the expected writeback
// every failed assertion adds one to fail_count
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module exec_core_checker
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    stall,
    input logic    flush,
    input logic    id_en,
    input id_ex_t  id,
    input logic    wb_en,
    input mem_wb_t wb
);

    int      fail_count = 0;
    // shadow of the instruction in MEM and the one at the WB port
    logic    m_en;
    ex_mem_t m_ins;
    logic    w_en;
    mem_wb_t w_ins;
    // set by the first issued instruction
    logic    issued;
    word_t   smem [dmem_depth];
    word_t   m_res;
    logic    m_wr;
    word_t   op_0;
    word_t   st_data;

    // integer functions, shifts by the low five bits
    function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_sll: return a << b[4:0];
            alu_srl: return a >> b[4:0];
            alu_sra: return word_t'($signed(a) >>> b[4:0]);
            default: return '0;
        endcase
    endfunction

    always_comb begin
        // load data or ALU value of the MEM instruction
        m_res   = (m_ins.mem_op == mem_load) ? smem[m_ins.ex_out[7:2]] : m_ins.ex_out;
        // r0 never forwards
        m_wr    = m_en && m_ins.gpr_we && (m_ins.dst_addr != '0);
        op_0    = (m_wr && m_ins.dst_addr == id.ra_addr) ? m_res : id.alu_in_0;
        st_data = (m_wr && m_ins.dst_addr == id.rb_addr) ? m_res : id.mem_wr_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_en   <= 1'b0;
            m_ins  <= '0;
            w_en   <= 1'b0;
            w_ins  <= '0;
            issued <= 1'b0;
            for (int i = 0; i < dmem_depth; i++) begin
                smem[i] <= '0;
            end
        end else begin
            if (id_en) begin
                issued <= 1'b1;
            end
            // stall freezes both shadow stages and the memory
            if (!stall) begin
                if (m_en && m_ins.mem_op == mem_store) begin
                    smem[m_ins.ex_out[7:2]] <= m_ins.mem_wr_data;
                end
                w_en  <= m_en;
                w_ins <= '{dst_addr: m_ins.dst_addr, gpr_we: m_ins.gpr_we, wb_data: m_res};
                // flushed instruction becomes a bubble
                m_en  <= id_en && !flush;
                m_ins <= '{mem_op: id.mem_op, mem_wr_data: st_data, dst_addr: id.dst_addr,
                           gpr_we: id.gpr_we, ex_out: alu_ref(id.alu_op, op_0, id.alu_in_1)};
            end
        end
    end

    // nothing comes out before the first issue
    a_idle: assert property (@(posedge clk) disable iff (!rst_n) !issued |-> !wb_en)
        else begin
            fail_count++;
            $error("wb_en went high at %0t before any instruction was issued", $time);
        end

    a_wb_en: assert property (@(posedge clk) disable iff (!rst_n) wb_en == w_en)
        else begin
            fail_count++;
            $error("** Error at %0t: wb_en expected %0b, got %0b",
                   $time, $sampled(w_en), $sampled(wb_en));
        end

    // payload covers dst_addr, gpr_we and wb_data
    a_wb: assert property (@(posedge clk) disable iff (!rst_n) wb_en |-> wb == w_ins)
        else begin
            fail_count++;
            $error("** Error at %0t: wb expected %h, got %h",
                   $time, $sampled(w_ins), $sampled(wb));
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                   stall |=> $stable(wb_en) && $stable(wb))
        else begin
            fail_count++;
            $error("writeback port changed at %0t while the pipeline was stalled", $time);
        end

endmodule

// every exec_core carries its checker
bind exec_core exec_core_checker u_checker (.*);

// File: verification/exec_core_tb.sv
////////////////////////////////////////////////////////////////////////////
// regression testbench for exec_core
// directed store, load, forwarding, stall and flush sequences, then
// LFSR driven random traffic, checked by the bound checker
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module exec_core_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    // about 400 stimulus cycles, the rest is margin
    localparam int timeout_cycles = 600;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        flush;
    logic        id_en;
    id_ex_t      id;
    logic        wb_en;
    mem_wb_t     wb;
    logic [15:0] lfsr_state;
    int          cycle_cnt;

    exec_core u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .flush (flush),
        .id_en (id_en),
        .id    (id),
        .wb_en (wb_en),
        .wb    (wb)
    );

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one LFSR step per bit
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    function automatic id_ex_t alu_instr(input alu_op_t op, input word_t a, input word_t b,
                                         input reg_addr_t ra, input reg_addr_t dst);
        id_ex_t ins;
        ins          = '0;
        ins.alu_op   = op;
        ins.alu_in_0 = a;
        ins.alu_in_1 = b;
        ins.ra_addr  = ra;
        ins.dst_addr = dst;
        ins.gpr_we   = 1'b1;
        return ins;
    endfunction

    // address is alu_in_0 + 0, only loads write a register
    function automatic id_ex_t mem_instr(input mem_op_t m, input word_t addr,
                                         input reg_addr_t rb, input word_t data,
                                         input reg_addr_t dst);
        id_ex_t ins;
        ins             = alu_instr(alu_add, addr, '0, '0, dst);
        ins.rb_addr     = rb;
        ins.mem_op      = m;
        ins.mem_wr_data = data;
        ins.gpr_we      = (m == mem_load);
        return ins;
    endfunction

    function automatic id_ex_t rand_instr();
        id_ex_t ins;
        word_t  sel;
        ins             = '0;
        sel             = rand_bits(3);
        ins.alu_op      = alu_op_t'({1'b0, sel[2:0]});
        ins.alu_in_0    = rand_bits(32);
        ins.alu_in_1    = rand_bits(32);
        ins.mem_wr_data = rand_bits(32);
        // registers 0..3 only, so hazards come often
        sel             = rand_bits(6);
        ins.ra_addr     = {3'b000, sel[1:0]};
        ins.rb_addr     = {3'b000, sel[3:2]};
        ins.dst_addr    = {3'b000, sel[5:4]};
        sel             = rand_bits(3);
        ins.gpr_we      = sel[0];
        if (sel[2]) begin
            // memory access inside a 16-word window
            ins.mem_op   = sel[1] ? mem_store : mem_load;
            ins.alu_op   = alu_add;
            ins.alu_in_1 = '0;
            sel          = rand_bits(4);
            ins.alu_in_0 = {26'd0, sel[3:0], 2'b00};
        end
        return ins;
    endfunction

    task automatic issue(input id_ex_t ins, input logic fl);
        @(posedge clk);
        id_en <= 1'b1;
        id    <= ins;
        stall <= 1'b0;
        flush <= fl;
    endtask

    // no issue while stalled
    task automatic idle_cycle(input logic st);
        @(posedge clk);
        id_en <= 1'b0;
        id    <= '0;
        stall <= st;
        flush <= 1'b0;
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, run did not finish within %0d cycles", timeout_cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        word_t sel;
        lfsr_state = 16'd97;
        rst_n      = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        id_en      = 1'b0;
        id         = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) idle_cycle(1'b0);
        // word never written reads zero
        issue(mem_instr(mem_load, 32'h80, 5'd0, 32'h0, 5'd1), 1'b0);
        issue(mem_instr(mem_store, 32'h40, 5'd0, 32'hA5A5_1234, 5'd0), 1'b0);
        issue(mem_instr(mem_load, 32'h40, 5'd0, 32'h0, 5'd2), 1'b0);
        // r5 into operand 0, then r6 into the store data
        issue(alu_instr(alu_add, 32'd100, 32'd23, 5'd0, 5'd5), 1'b0);
        issue(alu_instr(alu_xor, 32'hDEAD_BEEF, 32'h0000_00FF, 5'd5, 5'd6), 1'b0);
        issue(mem_instr(mem_store, 32'h44, 5'd6, 32'h1111_1111, 5'd0), 1'b0);
        issue(mem_instr(mem_load, 32'h44, 5'd0, 32'h0, 5'd7), 1'b0);
        // load to use
        issue(alu_instr(alu_sra, 32'h0, 32'd4, 5'd7, 5'd8), 1'b0);
        // r0 result must not be forwarded
        issue(alu_instr(alu_or, 32'h5, 32'h0, 5'd0, 5'd0), 1'b0);
        issue(alu_instr(alu_sub, 32'd50, 32'd8, 5'd0, 5'd9), 1'b0);
        // store parked in MEM over three stalled cycles
        issue(alu_instr(alu_sll, 32'h1, 32'd31, 5'd0, 5'd3), 1'b0);
        issue(mem_instr(mem_store, 32'h48, 5'd0, 32'h0BAD_F00D, 5'd0), 1'b0);
        repeat (3) idle_cycle(1'b1);
        issue(mem_instr(mem_load, 32'h48, 5'd0, 32'h0, 5'd4), 1'b0);
        // killed store, the word stays zero
        issue(mem_instr(mem_store, 32'h4C, 5'd0, 32'hFFFF_0000, 5'd0), 1'b1);
        issue(alu_instr(alu_add, 32'd7, 32'd7, 5'd0, 5'd10), 1'b1);
        issue(mem_instr(mem_load, 32'h4C, 5'd0, 32'h0, 5'd11), 1'b0);
        for (int i = 0; i < 300; i++) begin
            issue(rand_instr(), 1'b0);
        end
        // random mix, 1 in 8 stalls and 1 in 8 flushed
        for (int i = 0; i < 60; i++) begin
            sel = rand_bits(3);
            if (sel[2:0] == 3'd0) begin
                idle_cycle(1'b1);
            end else begin
                issue(rand_instr(), sel[2:0] == 3'd1);
            end
        end
        repeat (4) idle_cycle(1'b0);
        $display("exec_core run done, %0d assertion failures", u_dut.u_checker.fail_count);
        if (u_dut.u_checker.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: project.f
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/alu.sv
hw/pipe_reg.sv
hw/fwd_unit.sv
hw/ex_stage.sv
hw/mem_stage.sv
hw/exec_core.sv
verification/exec_core_checker.sv
verification/exec_core_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f project.f --top-module exec_core_tb \
    -o exec_core_sim || exit 1
./obj_dir/exec_core_sim +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -q "^Regression passed$" && exit 0 || exit 1
